// File: design/icache_params.svh
// Instruction cache sizes
// Address split, line geometry, way count and scrambling key widths

`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Fetch address, byte addressed and word aligned
`define IC_ADDR_W      32
`define IC_WORD_W      32
`define IC_BYTE_OFF_W  2

// Line geometry, two 32-bit beats per line
`define IC_LINE_BEATS  2
`define IC_BEAT_W      1
`define IC_LINE_W      (`IC_WORD_W * `IC_LINE_BEATS)

// Sets per way and tag width
`define IC_NUM_LINES   16
`define IC_INDEX_W     4
`define IC_TAG_W       (`IC_ADDR_W - `IC_INDEX_W - `IC_BEAT_W - `IC_BYTE_OFF_W)

`define IC_NUM_WAYS    2

// Scrambling key and nonce
`define SCR_KEY_W      128
`define SCR_NONCE_W    64

`endif

// File: design/icache_pkg.sv
// Instruction cache types
// Fetch response, bank request, scrambling key and controller states

`include "icache_params.svh"

package icache_pkg;

  // One response word with its bus error flag
  typedef struct packed {
    logic [`IC_WORD_W-1:0] rdata;
    logic                  err;
  } fetch_rsp_t;

  // Request shared by all banks, each bank has its own enable bit
  // Tag banks keep only the low IC_TAG_W bits of wdata
  typedef struct packed {
    logic                   write;
    logic [`IC_INDEX_W-1:0] index;
    logic [`IC_LINE_W-1:0]  wdata;
  } ram_req_t;

  typedef struct packed {
    logic [`SCR_KEY_W-1:0]   key;
    logic [`SCR_NONCE_W-1:0] nonce;
  } scr_key_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    FILL_REQ,
    FILL_WAIT,
    BYPASS_REQ,
    BYPASS_WAIT,
    RESPOND,
    INVAL
  } ctrl_state_e;

endpackage

// File: design/scr_key_mgr.sv
// Scrambling key manager
// Holds key and nonce, requests a fresh key after every invalidation

`timescale 1ns/100ps

`include "icache_params.svh"

module scr_key_mgr (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 inval_start_i,
  input  logic                 key_valid_i,
  input  icache_pkg::scr_key_t key_i,
  output logic                 key_req_o,
  output icache_pkg::scr_key_t key_o,
  output logic                 key_ready_o
);

  import icache_pkg::*;

  // Key in use straight out of reset
  localparam scr_key_t RstKey = '{
    key:   128'h3c8e_1f27_a0d4_96b5_7e12_c4f0_5a39_d86b,
    nonce: 64'h91e4_2b7c_06fd_a358
  };

  scr_key_t key_q;
  logic     req_q;
  logic     ready_q;
  logic     capture;

  assign capture = req_q && key_valid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q   <= 1'b0;
      ready_q <= 1'b1;
      key_q   <= RstKey;
    end else begin
      // Request rises after the invalidation and holds until a key is taken
      req_q <= req_q ? !key_valid_i : inval_start_i;
      if (capture) begin
        ready_q <= 1'b1;
        key_q   <= key_i;
      end else if (inval_start_i) begin
        ready_q <= 1'b0;
      end
    end
  end

  assign key_req_o   = req_q;
  assign key_o       = key_q;
  assign key_ready_o = ready_q;

endmodule

// File: design/scr_ram_1p.sv
// Scrambled single-port RAM
// Contents are XORed with a keystream from key, nonce and index; one-cycle read

`timescale 1ns/100ps

`include "icache_params.svh"

module scr_ram_1p #(
  parameter int unsigned Width = `IC_TAG_W
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_i,
  input  icache_pkg::ram_req_t ram_i,
  input  icache_pkg::scr_key_t key_i,
  output logic [Width-1:0]     rdata_o
);

  logic [Width-1:0]      mem_q [`IC_NUM_LINES];
  logic [Width-1:0]      rdata_q;
  logic [`IC_LINE_W-1:0] ks;

  // Upper key half, rotated lower half with nonce, and the repeated index
  function automatic logic [`IC_LINE_W-1:0] keystream(
    input logic [`SCR_KEY_W-1:0]   key,
    input logic [`SCR_NONCE_W-1:0] nonce,
    input logic [`IC_INDEX_W-1:0]  index
  );
    logic [`IC_LINE_W-1:0]   lo;
    logic [2*`IC_LINE_W-1:0] rot;
    lo  = key[`IC_LINE_W-1:0] ^ nonce;
    rot = {lo, lo} << index;
    return key[`SCR_KEY_W-1 -: `IC_LINE_W] ^ rot[2*`IC_LINE_W-1 -: `IC_LINE_W] ^
           {(`IC_LINE_W / `IC_INDEX_W){index}};
  endfunction

  assign ks = keystream(key_i.key, key_i.nonce, ram_i.index);

  always_ff @(posedge clk) begin
    if (req_i && ram_i.write) begin
      mem_q[ram_i.index] <= ram_i.wdata[Width-1:0] ^ ks[Width-1:0];
    end
  end

  // Read data decoded with the key in use at read time
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (req_i && !ram_i.write) begin
      rdata_q <= mem_q[ram_i.index] ^ ks[Width-1:0];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: design/icache_ctrl.sv
// Instruction cache controller
// Lookup, line fill, bypass and invalidation, with valid bits and
// per-set round-robin replacement

`timescale 1ns/100ps

`include "icache_params.svh"

module icache_ctrl #(
  parameter int unsigned NumWays = `IC_NUM_WAYS
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // Fetch side
  input  logic                   fetch_req_i,
  input  logic [`IC_ADDR_W-1:0]  fetch_addr_i,
  input  logic                   icache_enable_i,
  input  logic                   icache_inval_i,
  output logic                   busy_o,
  output logic                   rsp_valid_o,
  output icache_pkg::fetch_rsp_t rsp_o,
  // Memory side
  output logic                   mem_req_o,
  output logic [`IC_ADDR_W-1:0]  mem_addr_o,
  input  logic                   mem_gnt_i,
  input  logic                   mem_rvalid_i,
  input  logic [`IC_WORD_W-1:0]  mem_rdata_i,
  input  logic                   mem_err_i,
  // Banks
  output logic [NumWays-1:0]     tag_req_o,
  output logic [NumWays-1:0]     data_req_o,
  output icache_pkg::ram_req_t   ram_o,
  input  logic [`IC_TAG_W-1:0]   tag_rdata_i [NumWays],
  input  logic [`IC_LINE_W-1:0]  data_rdata_i [NumWays],
  // Key
  input  logic                   key_ready_i,
  output logic                   inval_start_o
);

  import icache_pkg::*;

  localparam int unsigned WayW = (NumWays > 1) ? $clog2(NumWays) : 1;
  localparam int unsigned LowW = `IC_BEAT_W + `IC_BYTE_OFF_W;

  ctrl_state_e state_q, state_d;

  logic [`IC_ADDR_W-1:0]                       addr_q;
  logic [`IC_BEAT_W-1:0]                       beat_q;
  logic                                        err_acc_q;
  logic                                        alloc_q;
  logic                                        inval_q;
  logic [NumWays-1:0][`IC_NUM_LINES-1:0]       valid_q;
  logic [`IC_NUM_LINES-1:0][WayW-1:0]          rr_q;
  logic [`IC_LINE_BEATS-1:0][`IC_WORD_W-1:0]   line_q;
  fetch_rsp_t                                  rsp_q;

  logic [`IC_INDEX_W-1:0]                      idx_q, fetch_idx;
  logic [`IC_TAG_W-1:0]                        tag_q;
  logic [`IC_BEAT_W-1:0]                       beat_sel, fetch_beat;
  logic [NumWays-1:0]                          hit_ways;
  logic [`IC_LINE_BEATS-1:0][`IC_WORD_W-1:0]   hit_line;
  logic                                        hit, accept, last_beat, tag_wr;
  logic [WayW-1:0]                             victim, next_victim;

  assign fetch_idx  = fetch_addr_i[LowW +: `IC_INDEX_W];
  assign fetch_beat = fetch_addr_i[`IC_BYTE_OFF_W +: `IC_BEAT_W];
  assign idx_q      = addr_q[LowW +: `IC_INDEX_W];
  assign tag_q      = addr_q[`IC_ADDR_W-1 -: `IC_TAG_W];
  assign beat_sel   = addr_q[`IC_BYTE_OFF_W +: `IC_BEAT_W];

  assign busy_o      = (state_q != IDLE) || inval_q || !key_ready_i;
  assign accept      = (state_q == IDLE) && fetch_req_i && !busy_o;
  assign last_beat   = (beat_q == `IC_BEAT_W'(`IC_LINE_BEATS - 1));
  assign victim      = rr_q[idx_q];
  assign next_victim = (victim == WayW'(NumWays - 1)) ? '0 : victim + 1'b1;

  // Tag goes in on the last beat, only when the whole line came back clean
  assign tag_wr = (state_q == FILL_WAIT) && mem_rvalid_i && last_beat &&
                  !(err_acc_q || mem_err_i);

  // Tag compare on the bank outputs of the previous cycle
  always_comb begin
    hit_ways = '0;
    hit_line = '0;
    for (int w = 0; w < NumWays; w++) begin
      hit_ways[w] = valid_q[w][idx_q] && (tag_rdata_i[w] == tag_q);
      if (hit_ways[w]) begin
        hit_line = hit_line | data_rdata_i[w];
      end
    end
  end

  assign hit = |hit_ways;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = icache_enable_i ? LOOKUP : BYPASS_REQ;
        end else if (inval_q || icache_inval_i) begin
          state_d = INVAL;
        end
      end
      LOOKUP:      state_d = hit ? RESPOND : FILL_REQ;
      FILL_REQ:    if (mem_gnt_i) state_d = FILL_WAIT;
      FILL_WAIT:   if (mem_rvalid_i) state_d = last_beat ? RESPOND : FILL_REQ;
      BYPASS_REQ:  if (mem_gnt_i) state_d = BYPASS_WAIT;
      BYPASS_WAIT: if (mem_rvalid_i) state_d = RESPOND;
      RESPOND:     state_d = IDLE;
      INVAL:       state_d = IDLE;
      default:     state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      beat_q    <= '0;
      err_acc_q <= 1'b0;
      alloc_q   <= 1'b0;
      inval_q   <= 1'b0;
      valid_q   <= '0;
      rr_q      <= '0;
    end else begin
      state_q <= state_d;
      // An invalidation during a fetch waits for the fetch to finish
      if (icache_inval_i) begin
        inval_q <= 1'b1;
      end else if (state_q == INVAL) begin
        inval_q <= 1'b0;
      end
      if (accept) begin
        beat_q    <= icache_enable_i ? '0 : fetch_beat;
        err_acc_q <= 1'b0;
        alloc_q   <= 1'b0;
      end
      if (state_q == FILL_WAIT && mem_rvalid_i) begin
        err_acc_q <= err_acc_q | mem_err_i;
        if (last_beat) begin
          alloc_q <= tag_wr;
        end else begin
          beat_q <= beat_q + 1'b1;
        end
      end
      if (state_q == RESPOND && alloc_q) begin
        valid_q[victim][idx_q] <= 1'b1;
        rr_q[idx_q]            <= next_victim;
      end
      if (state_q == INVAL) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
    // Loaded on a miss too, the fill overwrites it
    if (state_q == LOOKUP) begin
      rsp_q.rdata <= hit_line[beat_sel];
      rsp_q.err   <= 1'b0;
    end
    if ((state_q == FILL_WAIT || state_q == BYPASS_WAIT) && mem_rvalid_i) begin
      line_q[beat_q] <= mem_rdata_i;
      if (beat_q == beat_sel) begin
        rsp_q.rdata <= mem_rdata_i;
        rsp_q.err   <= mem_err_i;
      end
    end
  end

  // Bank requests: lookup read, tag write on last beat, data write in RESPOND
  always_comb begin
    tag_req_o  = '0;
    data_req_o = '0;
    if (accept && icache_enable_i) begin
      tag_req_o  = '1;
      data_req_o = '1;
    end else if (tag_wr) begin
      tag_req_o[victim] = 1'b1;
    end else if (state_q == RESPOND && alloc_q) begin
      data_req_o[victim] = 1'b1;
    end
  end

  // Tag and data writes share the bank bus, so they go in separate cycles
  always_comb begin
    ram_o.write = (state_q != IDLE);
    ram_o.index = (state_q == IDLE) ? fetch_idx : idx_q;
    ram_o.wdata = (state_q == RESPOND) ? line_q :
                  {{(`IC_LINE_W - `IC_TAG_W){1'b0}}, tag_q};
  end

  assign mem_req_o     = (state_q == FILL_REQ) || (state_q == BYPASS_REQ);
  assign mem_addr_o    = {addr_q[`IC_ADDR_W-1:LowW], beat_q, {`IC_BYTE_OFF_W{1'b0}}};
  assign rsp_valid_o   = (state_q == RESPOND);
  assign rsp_o         = rsp_q;
  assign inval_start_o = (state_q == INVAL);

endmodule

// File: design/icache_top.sv
// Instruction cache top
// Controller, key manager and one scrambled tag and data bank per way

`timescale 1ns/100ps

`include "icache_params.svh"

module icache_top #(
  parameter int unsigned NumWays = `IC_NUM_WAYS
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // Fetch side
  input  logic                   fetch_req_i,
  input  logic [`IC_ADDR_W-1:0]  fetch_addr_i,
  input  logic                   icache_enable_i,
  input  logic                   icache_inval_i,
  output logic                   busy_o,
  output logic                   rsp_valid_o,
  output icache_pkg::fetch_rsp_t rsp_o,
  // Memory side
  output logic                   mem_req_o,
  output logic [`IC_ADDR_W-1:0]  mem_addr_o,
  input  logic                   mem_gnt_i,
  input  logic                   mem_rvalid_i,
  input  logic [`IC_WORD_W-1:0]  mem_rdata_i,
  input  logic                   mem_err_i,
  // Key provider
  output logic                   key_req_o,
  input  logic                   key_valid_i,
  input  icache_pkg::scr_key_t   key_i
);

  import icache_pkg::*;

  ram_req_t              ram_req;
  logic [NumWays-1:0]    tag_req;
  logic [NumWays-1:0]    data_req;
  logic [`IC_TAG_W-1:0]  tag_rdata [NumWays];
  logic [`IC_LINE_W-1:0] data_rdata [NumWays];
  scr_key_t              scr_key;
  logic                  key_ready;
  logic                  inval_start;

  icache_ctrl #(
    .NumWays (NumWays)
  ) u_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_req_i     (fetch_req_i),
    .fetch_addr_i    (fetch_addr_i),
    .icache_enable_i (icache_enable_i),
    .icache_inval_i  (icache_inval_i),
    .busy_o          (busy_o),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_o           (rsp_o),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_gnt_i       (mem_gnt_i),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i),
    .mem_err_i       (mem_err_i),
    .tag_req_o       (tag_req),
    .data_req_o      (data_req),
    .ram_o           (ram_req),
    .tag_rdata_i     (tag_rdata),
    .data_rdata_i    (data_rdata),
    .key_ready_i     (key_ready),
    .inval_start_o   (inval_start)
  );

  scr_key_mgr u_key_mgr (
    .clk           (clk),
    .rst_n         (rst_n),
    .inval_start_i (inval_start),
    .key_valid_i   (key_valid_i),
    .key_i         (key_i),
    .key_req_o     (key_req_o),
    .key_o         (scr_key),
    .key_ready_o   (key_ready)
  );

  for (genvar w = 0; w < NumWays; w++) begin : gen_banks
    scr_ram_1p #(
      .Width (`IC_TAG_W)
    ) u_tag_bank (
      .clk     (clk),
      .rst_n   (rst_n),
      .req_i   (tag_req[w]),
      .ram_i   (ram_req),
      .key_i   (scr_key),
      .rdata_o (tag_rdata[w])
    );

    scr_ram_1p #(
      .Width (`IC_LINE_W)
    ) u_data_bank (
      .clk     (clk),
      .rst_n   (rst_n),
      .req_i   (data_req[w]),
      .ram_i   (ram_req),
      .key_i   (scr_key),
      .rdata_o (data_rdata[w])
    );
  end

endmodule

// File: tb/icache_monitor.sv
// Instruction cache monitor
// Predicts responses, hits and memory beats from a shadow of the cache lines

`timescale 1ns/100ps

`include "icache_params.svh"

module icache_monitor (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fetch_req_i,
  input  logic [`IC_ADDR_W-1:0]  fetch_addr_i,
  input  logic                   icache_enable_i,
  input  logic                   icache_inval_i,
  input  logic                   busy_o,
  input  logic                   rsp_valid_o,
  input  icache_pkg::fetch_rsp_t rsp_o,
  input  logic                   mem_req_o,
  input  logic [`IC_ADDR_W-1:0]  mem_addr_o,
  input  logic                   mem_gnt_i,
  input  logic                   key_req_o,
  input  logic                   key_valid_i,
  output int                     err_count_o,
  output int                     hit_count_o
);

  import icache_pkg::*;

  logic [`IC_TAG_W-1:0] tags [`IC_NUM_LINES][`IC_NUM_WAYS];
  logic                 valid [`IC_NUM_LINES][`IC_NUM_WAYS];
  int                   rr [`IC_NUM_LINES];
  int                   cycle, acc_cycle, beats;
  logic [31:0]          addr;
  logic                 pending, bypass, exp_hit, key_wait;

  // Reference memory contents, a fixed function of the word address
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return {a[15:0] ^ 16'ha5c3, ~a[15:0]} ^ {a[31:16], 16'h0};
  endfunction

  function automatic logic in_err_window(input logic [31:0] a);
    return (a >= 32'h400) && (a <= 32'h40f);
  endfunction

  task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("MISMATCH t=%0t %s exp=%h got=%h", $time, name, exp, got);
    err_count_o++;
  endtask

  task automatic failure(input string what);
    $display("ERROR t=%0t %s", $time, what);
    err_count_o++;
  endtask

  initial begin
    err_count_o = 0;
    hit_count_o = 0;
    pending     = 1'b0;
    key_wait    = 1'b0;
    cycle       = 0;
    for (int s = 0; s < `IC_NUM_LINES; s++) begin
      rr[s] = 0;
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
        valid[s][w] = 1'b0;
      end
    end
  end

  always @(posedge clk) begin : watch
    int                   set;
    logic [`IC_TAG_W-1:0] tag;
    logic [31:0]          exp_addr;
    logic                 line_err;
    cycle++;
    if (rst_n) begin
      if (key_wait && !busy_o) begin
        failure("busy_o low before the new key was delivered");
      end
      if (key_req_o && key_valid_i) begin
        key_wait = 1'b0;
      end else if (key_req_o) begin
        key_wait = 1'b1;
      end
      if (icache_inval_i) begin
        for (int s = 0; s < `IC_NUM_LINES; s++) begin
          for (int w = 0; w < `IC_NUM_WAYS; w++) begin
            valid[s][w] = 1'b0;
          end
        end
      end
      if (fetch_req_i && !busy_o) begin
        pending   = 1'b1;
        addr      = fetch_addr_i;
        bypass    = !icache_enable_i;
        acc_cycle = cycle;
        beats     = 0;
        exp_hit   = 1'b0;
        set       = addr[6:3];
        tag       = addr[31:7];
        for (int w = 0; w < `IC_NUM_WAYS; w++) begin
          if (!bypass && valid[set][w] && tags[set][w] == tag) begin
            exp_hit = 1'b1;
          end
        end
      end
      if (mem_req_o && mem_gnt_i) begin
        exp_addr = bypass ? addr : {addr[31:3], 3'b000} + 32'(beats * 4);
        if (mem_addr_o !== exp_addr) begin
          mismatch("mem_addr_o", exp_addr, mem_addr_o);
        end
        beats++;
      end
      if (rsp_valid_o) begin
        if (!pending) begin
          failure("rsp_valid_o without an accepted fetch");
        end else begin
          if (rsp_o.rdata !== mem_word(addr)) begin
            mismatch("rsp_o.rdata", mem_word(addr), rsp_o.rdata);
          end
          if (rsp_o.err !== in_err_window(addr)) begin
            mismatch("rsp_o.err", 32'(in_err_window(addr)), 32'(rsp_o.err));
          end
          if (exp_hit) begin
            hit_count_o++;
            if (cycle - acc_cycle != 2) begin
              mismatch("hit latency", 2, cycle - acc_cycle);
            end
            if (beats != 0) begin
              mismatch("hit memory beats", 0, beats);
            end
          end else if (beats != (bypass ? 1 : `IC_LINE_BEATS)) begin
            mismatch("memory beats", bypass ? 1 : `IC_LINE_BEATS, beats);
          end
          // Clean line fills are allocated into the round-robin way
          line_err = in_err_window({addr[31:3], 3'b000}) ||
                     in_err_window({addr[31:3], 3'b100});
          if (!bypass && !exp_hit && !line_err) begin
            set = addr[6:3];
            tags[set][rr[set]]  = addr[31:7];
            valid[set][rr[set]] = 1'b1;
            rr[set] = (rr[set] + 1) % `IC_NUM_WAYS;
          end
          pending = 1'b0;
        end
      end
    end
  end

endmodule

// File: tb/icache_chk.sv
// Instruction cache protocol checks
// Bound to the cache top, covers fetch, memory and key handshakes

`timescale 1ns/100ps

`include "icache_params.svh"

module icache_chk (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  fetch_req_i,
  input logic                  busy_o,
  input logic                  rsp_valid_o,
  input logic                  mem_req_o,
  input logic [`IC_ADDR_W-1:0] mem_addr_o,
  input logic                  mem_gnt_i,
  input logic                  key_req_o,
  input logic                  key_valid_i
);

  int fail_count = 0;

  // Response only while the cache is busy
  rsp_busy: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o |-> busy_o)
    else begin
      $error("rsp_valid_o high while busy_o low");
      fail_count++;
    end

  // Request and address held until granted
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o))
    else begin
      $error("mem_req_o dropped or mem_addr_o changed before grant");
      fail_count++;
    end

  fetch_idle: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_req_i |-> !busy_o)
    else begin
      $error("fetch_req_i while busy_o high");
      fail_count++;
    end

  key_fall: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(key_req_o) |-> $past(key_valid_i))
    else begin
      $error("key_req_o fell without key_valid_i");
      fail_count++;
    end

endmodule

bind icache_top icache_chk u_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .fetch_req_i (fetch_req_i),
  .busy_o      (busy_o),
  .rsp_valid_o (rsp_valid_o),
  .mem_req_o   (mem_req_o),
  .mem_addr_o  (mem_addr_o),
  .mem_gnt_i   (mem_gnt_i),
  .key_req_o   (key_req_o),
  .key_valid_i (key_valid_i)
);

// File: tb/tb_icache.sv
// Instruction cache testbench
// Clock, reset, memory and key models, random fetches and the test sequence

`timescale 1ns/100ps

`include "icache_params.svh"

module tb_icache;

  import icache_pkg::*;

  localparam int Timeout = 200;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        fetch_req_i, icache_enable_i, icache_inval_i;
  logic [31:0] fetch_addr_i;
  logic        busy_o, rsp_valid_o;
  fetch_rsp_t  rsp_o;
  logic        mem_req_o, mem_gnt_i, mem_rvalid_i, mem_err_i;
  logic [31:0] mem_addr_o, mem_rdata_i;
  logic        key_req_o, key_valid_i;
  scr_key_t    key_i;
  int          err_count, hit_count, last_errs, total_errs;
  integer      seed, mem_seed, key_seed;

  icache_top DUT (.*);

  icache_monitor u_mon (
    .clk (clk), .rst_n (rst_n), .fetch_req_i (fetch_req_i), .fetch_addr_i (fetch_addr_i),
    .icache_enable_i (icache_enable_i), .icache_inval_i (icache_inval_i), .busy_o (busy_o),
    .rsp_valid_o (rsp_valid_o), .rsp_o (rsp_o), .mem_req_o (mem_req_o),
    .mem_addr_o (mem_addr_o), .mem_gnt_i (mem_gnt_i), .key_req_o (key_req_o),
    .key_valid_i (key_valid_i), .err_count_o (err_count), .hit_count_o (hit_count)
  );

  always #10 clk = !clk;

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return {a[15:0] ^ 16'ha5c3, ~a[15:0]} ^ {a[31:16], 16'h0};
  endfunction

  // Eight groups of eight words that all land on sets 0 to 3
  function automatic logic [31:0] pool_addr(input int k);
    return 32'h400 + 32'((k / 8) * 32'h80) + 32'((k % 8) * 4);
  endfunction

  task automatic give_up(input string what);
    $display("Timeout while waiting for %s", what);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy_o) begin
      @(negedge clk);
      n++;
      if (n > Timeout) give_up("busy_o to fall");
    end
  endtask

  task automatic fetch(input logic [31:0] a);
    int n;
    wait_idle();
    fetch_req_i  = 1'b1;
    fetch_addr_i = a;
    @(negedge clk);
    fetch_req_i = 1'b0;
    n = 0;
    while (!rsp_valid_o) begin
      @(negedge clk);
      n++;
      if (n > Timeout) give_up("rsp_valid_o");
    end
    @(negedge clk);
  endtask

  task automatic invalidate();
    int n;
    wait_idle();
    icache_inval_i = 1'b1;
    @(negedge clk);
    icache_inval_i = 1'b0;
    n = 0;
    while (!key_req_o) begin
      @(negedge clk);
      n++;
      if (n > Timeout) give_up("key_req_o to rise");
    end
    wait_idle();
  endtask

  task automatic report(input string name);
    $display("test %s: %0d errors", name, err_count - last_errs);
    last_errs = err_count;
  endtask

  // Memory grants after 0 to 3 cycles and answers 1 to 3 cycles later
  initial begin : memory
    int          d;
    logic [31:0] a;
    forever begin
      @(negedge clk);
      if (mem_req_o) begin
        d = $unsigned($random(mem_seed)) % 4;
        repeat (d) @(negedge clk);
        a = mem_addr_o;
        mem_gnt_i = 1'b1;
        @(negedge clk);
        mem_gnt_i = 1'b0;
        d = $unsigned($random(mem_seed)) % 3;
        repeat (d) @(negedge clk);
        mem_rvalid_i = 1'b1;
        mem_rdata_i  = mem_word(a);
        mem_err_i    = (a >= 32'h400) && (a <= 32'h40f);
        @(negedge clk);
        mem_rvalid_i = 1'b0;
        mem_err_i    = 1'b0;
      end
    end
  end

  initial begin : key_provider
    int d;
    forever begin
      @(negedge clk);
      if (key_req_o) begin
        d = $unsigned($random(key_seed)) % 4;
        repeat (d) @(negedge clk);
        key_i = {$random(key_seed), $random(key_seed), $random(key_seed),
                 $random(key_seed), $random(key_seed), $random(key_seed)};
        key_valid_i = 1'b1;
        @(negedge clk);
        key_valid_i = 1'b0;
      end
    end
  end

  initial begin
    seed     = 32'h5fce4d1e;
    mem_seed = seed ^ 32'h1234_5678;
    key_seed = seed ^ 32'h0bad_cafe;
    rst_n = 1'b0;
    fetch_req_i = 1'b0;
    fetch_addr_i = '0;
    icache_enable_i = 1'b1;
    icache_inval_i = 1'b0;
    mem_gnt_i = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i = '0;
    mem_err_i = 1'b0;
    key_valid_i = 1'b0;
    key_i = '0;
    last_errs = 0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    for (int i = 0; i < 60; i++) fetch(pool_addr($unsigned($random(seed)) % 64));
    report("1 random fetches");

    for (int i = 0; i < 10; i++) begin
      fetch_addr_i = pool_addr(8 + $unsigned($random(seed)) % 56);
      fetch(fetch_addr_i);
      fetch(fetch_addr_i);
    end
    report("2 repeated fetch hits");

    fetch(32'h484);
    invalidate();
    fetch(32'h484);
    fetch(32'h484);
    report("3 invalidation and new key");

    fetch(32'h404);
    fetch(32'h404);
    report("4 error line not cached");

    icache_enable_i = 1'b0;
    for (int k = 0; k < 8; k++) fetch(32'h2000 + 32'(k * 4));
    icache_enable_i = 1'b1;
    for (int k = 0; k < 8; k++) fetch(32'h2000 + 32'(k * 4));
    report("5 bypass");

    total_errs = err_count + DUT.u_chk.fail_count;
    $display("tests 5 hits %0d errors %0d", hit_count, total_errs);
    if (hit_count == 0) begin
      $display("No fetch hit the cache");
    end
    if (total_errs == 0 && hit_count > 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+design
design/icache_pkg.sv
design/scr_key_mgr.sv
design/scr_ram_1p.sv
design/icache_ctrl.sv
design/icache_top.sv
tb/icache_monitor.sv
tb/icache_chk.sv
tb/tb_icache.sv
